// ==== sources.f ====
verilog/clock_pkg.sv
verilog/display_pkg.sv
verilog/tick_gen.sv
verilog/key_debounce.sv
verilog/mode_ctrl.sv
verilog/time_counter.sv
verilog/alarm_unit.sv
verilog/display_scan.sv
verilog/clock_top.sv
testbench/clock_tb.sv

// ==== Makefile ====
# Verilator simulation of the clock testbench

VERILATOR ?= verilator
TOP       ?= clock_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/clock_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_tb;

	import clock_pkg::*;
	import display_pkg::*;

	localparam int SEC_DIV     = 400;
	localparam int DEB_DIV     = 4;
	localparam int SCAN_DIV    = 2;
	localparam int KEY_HOLD    = 20;
	localparam int DAY_SECONDS = 86400;
	localparam int ALARM_LEAD  = 4;

	// Run limit from worst-case key presses and waiting seconds
	localparam int PRESS_CYCLES   = 2 * KEY_HOLD + 1;
	localparam int MAX_PRESSES    = 900;
	localparam int WAIT_SECONDS   = 30;
	localparam int TIMEOUT_CYCLES = MAX_PRESSES * PRESS_CYCLES + WAIT_SECONDS * SEC_DIV + 2000;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic [KEY_COUNT-1:0] key;
	logic [SEG_W-1:0]     seg;
	logic [DIGITS-1:0]    seg_enb;
	logic                 seg_dp;
	logic                 alarm;

	integer      seed = 32'hb90d_de99;
	int          cycle_cnt = 0;
	int          error_count = 0;
	int          check_count = 0;
	int          test_errors = 0;
	int          ref_time = 0;
	int          ref_alarm = 0;
	int          last_h, last_m;
	string       name_q [$];
	logic [31:0] act_q [$];
	logic [31:0] exp_q [$];
	event        check_ev;

	clock_top #(
		.SEC_DIV  (SEC_DIV),
		.DEB_DIV  (DEB_DIV),
		.SCAN_DIV (SCAN_DIV)
	) clock_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_key     (key),
		.o_seg     (seg),
		.o_seg_enb (seg_enb),
		.o_seg_dp  (seg_dp),
		.o_alarm   (alarm)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic int to_sod(input int h, input int m, input int s);
		return h * 3600 + m * 60 + s;
	endfunction

	function automatic int advance(input int sod, input int k);
		return (sod + k) % DAY_SECONDS;
	endfunction

	// Field after n increments without carry out
	function automatic int field_after(input int value, input int n, input int max_value);
		return (value + n) % (max_value + 1);
	endfunction

	function automatic logic [31:0] pack_fields(input int h, input int m, input int s);
		return {8'd0, 8'(h), 8'(m), 8'(s)};
	endfunction

	function automatic logic [31:0] pack_sod(input int sod);
		return pack_fields(sod / 3600, (sod / 60) % 60, sod % 60);
	endfunction

	// Digit 0 point shows mode bit 0 and digit 1 shows bit 1
	function automatic logic [31:0] dp_for_mode(input mode_t mode);
		logic [1:0] bits;
		bits = mode;
		return {30'd0, bits};
	endfunction

	function automatic int digit_of_seg(input logic [6:0] pattern);
		case (pattern)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_0011: return 9;
			default:     return 15;
		endcase
	endfunction

	// --------------------------------------------------
	// Compare process
	// --------------------------------------------------
	always @(check_ev) begin
		string       name;
		logic [31:0] act;
		logic [31:0] exp;
		while (exp_q.size() > 0) begin
			name = name_q.pop_front();
			act  = act_q.pop_front();
			exp  = exp_q.pop_front();
			check_count++;
			assert (act === exp) else begin
				$display("mismatch %s: got 0x%0h, expected 0x%0h", name, act, exp);
				error_count++;
			end
		end
	end

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		name_q.push_back(name);
		act_q.push_back(actual);
		exp_q.push_back(expected);
		-> check_ev;
	endtask

	task automatic finish_test(input string name);
		int n;
		@(negedge clk);
		n = error_count - test_errors;
		if (n == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, n);
		end
		test_errors = error_count;
	endtask

	// --------------------------------------------------
	// Key and display access
	// --------------------------------------------------
	task automatic press_key(input int k);
		@(posedge clk);
		key[k] <= 1'b1;
		repeat (KEY_HOLD) @(posedge clk);
		key[k] <= 1'b0;
		repeat (KEY_HOLD) @(posedge clk);
	endtask

	// Ends back at the seconds position
	task automatic inc_fields(input int n_s, input int n_m, input int n_h);
		repeat (n_s) press_key(KEY_INC);
		press_key(KEY_POS);
		repeat (n_m) press_key(KEY_INC);
		press_key(KEY_POS);
		repeat (n_h) press_key(KEY_INC);
		press_key(KEY_POS);
	endtask

	task automatic set_fields(input int from_sod, input int to_sod_val);
		int n_s;
		int n_m;
		int n_h;
		n_s = (to_sod_val % 60 - from_sod % 60 + 60) % 60;
		n_m = ((to_sod_val / 60) % 60 - (from_sod / 60) % 60 + 60) % 60;
		n_h = (to_sod_val / 3600 - from_sod / 3600 + 24) % 24;
		inc_fields(n_s, n_m, n_h);
	endtask

	// One segment word per enabled digit over a full scan
	task automatic read_display(output int h, output int m, output int s,
			output logic [5:0] dp);
		int         val [DIGITS];
		logic [5:0] seen;
		logic [5:0] want;
		seen = '0;
		dp   = '0;
		for (int d = 0; d < DIGITS; d++) begin
			val[d] = 15;
		end
		repeat (DIGITS * SCAN_DIV + 2) begin
			@(negedge clk);
			for (int d = 0; d < DIGITS; d++) begin
				want = ~(6'b00_0001 << d);
				if (seg_enb == want) begin
					val[d]  = digit_of_seg(seg);
					dp[d]   = seg_dp;
					seen[d] = 1'b1;
				end
			end
		end
		assert (seen == 6'b11_1111) else begin
			$display("not every digit was enabled during a scan, seen 0x%0h", seen);
			error_count++;
		end
		s = val[1] * 10 + val[0];
		m = val[3] * 10 + val[2];
		h = val[5] * 10 + val[4];
		last_h = h;
		last_m = m;
	endtask

	task automatic expect_display(input string name, input int sod, input mode_t mode);
		int         h, m, s;
		logic [5:0] dp;
		read_display(h, m, s, dp);
		compare({name, " o_seg"}, pack_fields(h, m, s), pack_sod(sod));
		compare({name, " o_seg_dp"}, 32'(dp), dp_for_mode(mode));
	endtask

	// Frozen setup time against k seconds of running near the estimate
	task automatic check_frozen(input string name, input int t_leave, input int t_enter);
		int         h, m, s;
		logic [5:0] dp;
		int         got;
		int         est;
		int         expect_sod;
		read_display(h, m, s, dp);
		got = to_sod(h, m, s);
		est = (t_enter - t_leave + SEC_DIV / 2) / SEC_DIV;
		expect_sod = advance(ref_time, est);
		for (int k = est - 2; k <= est + 2; k++) begin
			if (k >= 0 && advance(ref_time, k) == got) begin
				expect_sod = advance(ref_time, k);
			end
		end
		compare({name, " o_seg"}, pack_fields(h, m, s), pack_sod(expect_sod));
		compare({name, " o_seg_dp"}, 32'(dp), dp_for_mode(MODE_SETUP));
		ref_time = expect_sod;
	endtask

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial begin
		int n_s, n_m, n_h;
		int t0, t1;
		int rise;
		logic flag;
		rst_n <= 1'b0;
		key   <= '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		expect_display("reset", 0, MODE_CLOCK);
		compare("reset o_alarm", 32'(alarm), 32'd0);
		finish_test("test 1 reset state");

		press_key(KEY_MODE);
		expect_display("setup entry", 0, MODE_SETUP);
		n_s = $random(seed) & 63;
		n_m = $random(seed) & 63;
		n_h = $random(seed) & 31;
		inc_fields(n_s, n_m, n_h);
		ref_time = to_sod(field_after(0, n_h, HOUR_MAX), field_after(0, n_m, MIN_MAX),
			field_after(0, n_s, SEC_MAX));
		expect_display("setup increments", ref_time, MODE_SETUP);
		repeat (3 * SEC_DIV) @(posedge clk);
		expect_display("setup frozen", ref_time, MODE_SETUP);
		finish_test("test 2 setup");

		set_fields(ref_time, to_sod(23, 59, 55));
		ref_time = to_sod(23, 59, 55);
		expect_display("preset", ref_time, MODE_SETUP);
		t0 = cycle_cnt;
		press_key(KEY_MODE);
		press_key(KEY_MODE);
		repeat (8 * SEC_DIV) @(posedge clk);
		t1 = cycle_cnt;
		press_key(KEY_MODE);
		check_frozen("carry", t0, t1);
		assert (last_h == 0 && last_m == 0) else begin
			$display("time did not roll over midnight, hours %0d minutes %0d", last_h, last_m);
			error_count++;
		end
		finish_test("test 3 running with carry");

		t0 = cycle_cnt;
		press_key(KEY_MODE);
		expect_display("alarm entry", 0, MODE_ALARM);
		n_s = $random(seed) & 15;
		n_m = $random(seed) & 15;
		n_h = $random(seed) & 15;
		inc_fields(n_s, n_m, n_h);
		ref_alarm = to_sod(field_after(0, n_h, HOUR_MAX), field_after(0, n_m, MIN_MAX),
			field_after(0, n_s, SEC_MAX));
		expect_display("alarm increments", ref_alarm, MODE_ALARM);
		press_key(KEY_MODE);
		t1 = cycle_cnt;
		press_key(KEY_MODE);
		check_frozen("time during alarm setting", t0, t1);
		finish_test("test 4 alarm setting");

		// Alarm a few seconds ahead of the frozen time
		set_fields(ref_time, advance(ref_alarm, DAY_SECONDS - ALARM_LEAD));
		ref_time = advance(ref_alarm, DAY_SECONDS - ALARM_LEAD);
		expect_display("before alarm", ref_time, MODE_SETUP);
		press_key(KEY_ALARM);
		compare("armed o_alarm", 32'(alarm), 32'd0);
		t0 = cycle_cnt;
		press_key(KEY_MODE);
		press_key(KEY_MODE);
		rise = -1;
		while (rise < 0 && cycle_cnt - t0 <= (ALARM_LEAD + 1) * SEC_DIV) begin
			@(negedge clk);
			if (alarm) begin
				rise = cycle_cnt - t0;
			end
		end
		assert (rise >= (ALARM_LEAD - 1) * SEC_DIV) else begin
			$display("o_alarm did not rise in its window, rise cycle %0d", rise);
			error_count++;
		end
		flag = 1'b0;
		repeat (2 * SEC_DIV) begin
			@(negedge clk);
			if (!alarm) begin
				flag = 1'b1;
			end
		end
		assert (!flag) else begin
			$display("o_alarm dropped while the alarm was still enabled");
			error_count++;
		end
		press_key(KEY_ALARM);
		compare("disabled o_alarm", 32'(alarm), 32'd0);
		t1 = cycle_cnt;
		press_key(KEY_MODE);
		check_frozen("after alarm", t0, t1);

		// Second match with the alarm off
		set_fields(ref_time, advance(ref_alarm, DAY_SECONDS - 2));
		press_key(KEY_MODE);
		press_key(KEY_MODE);
		flag = 1'b0;
		repeat (6 * SEC_DIV) begin
			@(negedge clk);
			if (alarm) begin
				flag = 1'b1;
			end
		end
		assert (!flag) else begin
			$display("o_alarm rose on a match while the alarm was disabled");
			error_count++;
		end
		finish_test("test 5 alarm match");

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/clock_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_top #(
	parameter logic [31:0] SEC_DIV  = clock_pkg::SEC_DIV_DEFAULT,
	parameter logic [31:0] DEB_DIV  = clock_pkg::DEB_DIV_DEFAULT,
	parameter logic [31:0] SCAN_DIV = clock_pkg::SCAN_DIV_DEFAULT
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [clock_pkg::KEY_COUNT-1:0] i_key,
	output display_pkg::seg_t               o_seg,
	output logic [display_pkg::DIGITS-1:0]  o_seg_enb,
	output logic                            o_seg_dp,
	output logic                            o_alarm
);

	import clock_pkg::*;

	logic                 sec_tick;
	logic                 deb_tick;
	logic                 scan_tick;
	logic [KEY_COUNT-1:0] press;
	mode_t                mode;
	logic                 time_run;
	logic [2:0]           set_inc;
	logic [2:0]           alarm_inc;
	logic                 alarm_en;
	field_t               sec, min, hour;
	field_t               alarm_sec, alarm_min, alarm_hour;

	// --------------------------------------------------
	// Tick enables
	// --------------------------------------------------
	tick_gen #(.DIV(SEC_DIV)) sec_tick_gen_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIV(DEB_DIV)) deb_tick_gen_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (deb_tick)
	);

	tick_gen #(.DIV(SCAN_DIV)) scan_tick_gen_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	// One debouncer per button
	for (genvar k = 0; k < KEY_COUNT; k++) begin : gen_key
		key_debounce key_debounce_i (
			.clk      (clk),
			.rst_n    (rst_n),
			.i_sample (deb_tick),
			.i_key    (i_key[k]),
			.o_press  (press[k])
		);
	end

	// --------------------------------------------------
	// Control, time keeping and display
	// --------------------------------------------------
	mode_ctrl mode_ctrl_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_press     (press),
		.o_mode      (mode),
		.o_position  (),
		.o_time_run  (time_run),
		.o_set_inc   (set_inc),
		.o_alarm_inc (alarm_inc),
		.o_alarm_en  (alarm_en)
	);

	time_counter time_counter_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_tick    (sec_tick),
		.i_run     (time_run),
		.i_set_inc (set_inc),
		.o_sec     (sec),
		.o_min     (min),
		.o_hour    (hour)
	);

	alarm_unit alarm_unit_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_alarm_inc  (alarm_inc),
		.i_alarm_en   (alarm_en),
		.i_sec        (sec),
		.i_min        (min),
		.i_hour       (hour),
		.o_alarm_sec  (alarm_sec),
		.o_alarm_min  (alarm_min),
		.o_alarm_hour (alarm_hour),
		.o_alarm      (o_alarm)
	);

	display_scan display_scan_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_scan       (scan_tick),
		.i_mode       (mode),
		.i_sec        (sec),
		.i_min        (min),
		.i_hour       (hour),
		.i_alarm_sec  (alarm_sec),
		.i_alarm_min  (alarm_min),
		.i_alarm_hour (alarm_hour),
		.o_seg        (o_seg),
		.o_seg_enb    (o_seg_enb),
		.o_seg_dp     (o_seg_dp)
	);

endmodule

`default_nettype wire

// ==== verilog/display_scan.sv ====
`timescale 1ns/1ns
`default_nettype none

module display_scan (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            i_scan,
	input  clock_pkg::mode_t                i_mode,
	input  clock_pkg::field_t               i_sec,
	input  clock_pkg::field_t               i_min,
	input  clock_pkg::field_t               i_hour,
	input  clock_pkg::field_t               i_alarm_sec,
	input  clock_pkg::field_t               i_alarm_min,
	input  clock_pkg::field_t               i_alarm_hour,
	output display_pkg::seg_t               o_seg,
	output logic [display_pkg::DIGITS-1:0]  o_seg_enb,
	output logic                            o_seg_dp
);

	import clock_pkg::*;
	import display_pkg::*;

	localparam int IDX_W = $clog2(DIGITS);

	logic [IDX_W-1:0] digit_idx;
	field_t           show_sec;
	field_t           show_min;
	field_t           show_hour;
	logic [3:0]       digit_val [DIGITS];

	// --------------------------------------------------
	// Digit scan counter
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			digit_idx <= '0;
		end else if (i_scan) begin
			if (digit_idx == IDX_W'(DIGITS - 1)) begin
				digit_idx <= '0;
			end else begin
				digit_idx <= digit_idx + 1'b1;
			end
		end
	end

	// Alarm time only in alarm mode
	always_comb begin
		if (i_mode == MODE_ALARM) begin
			show_sec  = i_alarm_sec;
			show_min  = i_alarm_min;
			show_hour = i_alarm_hour;
		end else begin
			show_sec  = i_sec;
			show_min  = i_min;
			show_hour = i_hour;
		end
	end

	// Ones digit first, seconds on the right
	always_comb begin
		digit_val[0] = 4'(show_sec % 6'd10);
		digit_val[1] = 4'(show_sec / 6'd10);
		digit_val[2] = 4'(show_min % 6'd10);
		digit_val[3] = 4'(show_min / 6'd10);
		digit_val[4] = 4'(show_hour % 6'd10);
		digit_val[5] = 4'(show_hour / 6'd10);
	end

	// --------------------------------------------------
	// Outputs for the active digit
	// --------------------------------------------------
	assign o_seg     = seg_of_digit(digit_val[digit_idx]);
	assign o_seg_enb = ~(DIGITS'(1) << digit_idx);

	// Decimal points carry the mode bits
	always_comb begin
		case (digit_idx)
			IDX_W'(0): o_seg_dp = i_mode[0];
			IDX_W'(1): o_seg_dp = i_mode[1];
			default:   o_seg_dp = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/alarm_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module alarm_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [2:0]        i_alarm_inc,
	input  logic              i_alarm_en,
	input  clock_pkg::field_t i_sec,
	input  clock_pkg::field_t i_min,
	input  clock_pkg::field_t i_hour,
	output clock_pkg::field_t o_alarm_sec,
	output clock_pkg::field_t o_alarm_min,
	output clock_pkg::field_t o_alarm_hour,
	output logic              o_alarm
);

	import clock_pkg::*;

	logic match;

	// Alarm time, set one field at a time
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_sec  <= '0;
			o_alarm_min  <= '0;
			o_alarm_hour <= '0;
		end else begin
			if (i_alarm_inc[POS_SEC]) begin
				o_alarm_sec <= field_wrap_inc(o_alarm_sec, SEC_MAX);
			end
			if (i_alarm_inc[POS_MIN]) begin
				o_alarm_min <= field_wrap_inc(o_alarm_min, MIN_MAX);
			end
			if (i_alarm_inc[POS_HOUR]) begin
				o_alarm_hour <= field_wrap_inc(o_alarm_hour, HOUR_MAX);
			end
		end
	end

	assign match = (i_sec == o_alarm_sec) && (i_min == o_alarm_min) && (i_hour == o_alarm_hour);

	// Latched level, held until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (o_alarm | match);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/time_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module time_counter (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_tick,
	input  logic              i_run,
	input  logic [2:0]        i_set_inc,
	output clock_pkg::field_t o_sec,
	output clock_pkg::field_t o_min,
	output clock_pkg::field_t o_hour
);

	import clock_pkg::*;

	logic step;
	logic sec_wrap;
	logic min_wrap;

	assign step     = i_tick & i_run;
	assign sec_wrap = (o_sec >= SEC_MAX);
	assign min_wrap = (o_min >= MIN_MAX);

	// --------------------------------------------------
	// Running count and manual setting
	// --------------------------------------------------
	// Setting never overlaps a step, run is low in setup
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec  <= '0;
			o_min  <= '0;
			o_hour <= '0;
		end else if (step) begin
			o_sec <= field_wrap_inc(o_sec, SEC_MAX);
			// Carry ripples only through wrapping fields
			if (sec_wrap) begin
				o_min <= field_wrap_inc(o_min, MIN_MAX);
				if (min_wrap) begin
					o_hour <= field_wrap_inc(o_hour, HOUR_MAX);
				end
			end
		end else begin
			// Each field wraps on its own, no carry
			if (i_set_inc[POS_SEC]) begin
				o_sec <= field_wrap_inc(o_sec, SEC_MAX);
			end
			if (i_set_inc[POS_MIN]) begin
				o_min <= field_wrap_inc(o_min, MIN_MAX);
			end
			if (i_set_inc[POS_HOUR]) begin
				o_hour <= field_wrap_inc(o_hour, HOUR_MAX);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mode_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module mode_ctrl (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [clock_pkg::KEY_COUNT-1:0] i_press,
	output clock_pkg::mode_t                o_mode,
	output clock_pkg::pos_t                 o_position,
	output logic                            o_time_run,
	output logic [2:0]                      o_set_inc,
	output logic [2:0]                      o_alarm_inc,
	output logic                            o_alarm_en
);

	import clock_pkg::*;

	logic [2:0] field_sel;

	// One-hot field strobe for the current position
	assign field_sel = 3'b001 << o_position;

	// Clock keeps running except while being set
	assign o_time_run = (o_mode != MODE_SETUP);

	// --------------------------------------------------
	// Mode, position and alarm enable
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
		end else if (i_press[KEY_MODE]) begin
			case (o_mode)
				MODE_CLOCK: o_mode <= MODE_SETUP;
				MODE_SETUP: o_mode <= MODE_ALARM;
				default:    o_mode <= MODE_CLOCK;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_position <= POS_SEC;
		end else if (i_press[KEY_POS]) begin
			case (o_position)
				POS_SEC: o_position <= POS_MIN;
				POS_MIN: o_position <= POS_HOUR;
				default: o_position <= POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_en <= 1'b0;
		end else if (i_press[KEY_ALARM]) begin
			o_alarm_en <= ~o_alarm_en;
		end
	end

	// --------------------------------------------------
	// Increment routing
	// --------------------------------------------------
	// Ignored in clock mode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_set_inc   <= '0;
			o_alarm_inc <= '0;
		end else begin
			o_set_inc   <= '0;
			o_alarm_inc <= '0;
			if (i_press[KEY_INC]) begin
				case (o_mode)
					MODE_SETUP: o_set_inc   <= field_sel;
					MODE_ALARM: o_alarm_inc <= field_sel;
					default:    ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/key_debounce.sv ====
`timescale 1ns/1ns
`default_nettype none

module key_debounce (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sample,
	input  logic i_key,
	output logic o_press
);

	// Two stored samples with the older one in bit 1
	logic [1:0] history;
	logic [2:0] history_next;

	assign history_next = {history, i_key};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			history <= '0;
		end else if (i_sample) begin
			history <= history_next[1:0];
		end
	end

	// --------------------------------------------------
	// Press detect
	// --------------------------------------------------
	// Low followed by two highs so a held key fires once
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_press <= 1'b0;
		end else begin
			o_press <= i_sample && (history_next == 3'b011);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tick_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tick_gen #(
	parameter logic [31:0] DIV = 32'd2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	// At least one bit, even for a divide by one
	localparam int CNT_W = (DIV > 32'd1) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0] cnt;

	// One-cycle strobe every DIV cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == CNT_W'(DIV - 32'd1)) begin
			cnt    <= '0;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/display_pkg.sv ====
`default_nettype none

package display_pkg;

	localparam int DIGITS = 6;
	localparam int SEG_W  = 7;

	// Segment a in the top bit down to g, lit when high
	typedef logic [SEG_W-1:0] seg_t;

	localparam seg_t SEG_BLANK = '0;

	// --------------------------------------------------
	// Decimal digit to seven-segment pattern
	// --------------------------------------------------
	function automatic seg_t seg_of_digit(input logic [3:0] digit);
		seg_t seg;
		case (digit)
			4'd0:    seg = 7'b111_1110;
			4'd1:    seg = 7'b011_0000;
			4'd2:    seg = 7'b110_1101;
			4'd3:    seg = 7'b111_1001;
			4'd4:    seg = 7'b011_0011;
			4'd5:    seg = 7'b101_1011;
			4'd6:    seg = 7'b101_1111;
			4'd7:    seg = 7'b111_0000;
			4'd8:    seg = 7'b111_1111;
			4'd9:    seg = 7'b111_0011;
			default: seg = SEG_BLANK;
		endcase
		return seg;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/clock_pkg.sv ====
`default_nettype none

package clock_pkg;

	// --------------------------------------------------
	// Time fields
	// --------------------------------------------------
	localparam int FIELD_W = 6;

	typedef logic [FIELD_W-1:0] field_t;

	localparam field_t SEC_MAX  = 6'd59;
	localparam field_t MIN_MAX  = 6'd59;
	localparam field_t HOUR_MAX = 6'd23;

	// Operating mode and selected field
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_t;

	// Button order on the key vector
	localparam int KEY_COUNT = 4;
	localparam int KEY_MODE  = 0;
	localparam int KEY_POS   = 1;
	localparam int KEY_INC   = 2;
	localparam int KEY_ALARM = 3;

	// Divider defaults for a 50 MHz board clock
	localparam logic [31:0] SEC_DIV_DEFAULT  = 32'd50_000_000;
	localparam logic [31:0] DEB_DIV_DEFAULT  = 32'd500_000;
	localparam logic [31:0] SCAN_DIV_DEFAULT = 32'd5_000;

	// One step of a field, back to zero past its maximum
	function automatic field_t field_wrap_inc(input field_t value, input field_t max_value);
		if (value >= max_value) begin
			return '0;
		end
		return field_t'(value + 1'b1);
	endfunction

endpackage

`default_nettype wire
